/* verilog.f */
+incdir+hdl
+incdir+bench
hdl/md_pkg.sv
hdl/md_decode.sv
hdl/md_req_fifo.sv
hdl/md_iter_unit.sv
hdl/md_top.sv
bench/md_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = md_tb
FILELIST = verilog.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* bench/md_tb_model.svh */
/*
 * Expected result of one request, from the RV32M and base shift rules.
 * Only shift and M encodings are covered. Included inside the testbench module.
 */
`ifndef MD_TB_MODEL_SVH
`define MD_TB_MODEL_SVH

function automatic logic [`MD_XLEN-1:0] model_result(
	input logic [2:0]          funct3,
	input logic                alt,
	input logic                m_ext,
	input logic [`MD_XLEN-1:0] a,
	input logic [`MD_XLEN-1:0] b
);
	logic [4:0]                 amt;
	logic [2*`MD_XLEN-1:0]      a_sx;
	logic [2*`MD_XLEN-1:0]      a_zx;
	logic [2*`MD_XLEN-1:0]      b_sx;
	logic [2*`MD_XLEN-1:0]      b_zx;
	logic [2*`MD_XLEN-1:0]      prod;
	logic signed [`MD_XLEN-1:0] sa;
	logic signed [`MD_XLEN-1:0] sb;
	logic [`MD_XLEN-1:0]        min_int;
	logic                       b_zero;
	logic                       ovf;

	amt     = b[4:0];  // upper bits of rs2 ignored
	sa      = a;
	sb      = b;
	a_sx    = {{`MD_XLEN{a[`MD_XLEN-1]}}, a};
	a_zx    = {{`MD_XLEN{1'b0}}, a};
	b_sx    = {{`MD_XLEN{b[`MD_XLEN-1]}}, b};
	b_zx    = {{`MD_XLEN{1'b0}}, b};
	prod    = '0;
	min_int = {1'b1, {(`MD_XLEN-1){1'b0}}};
	b_zero  = (b == '0);
	ovf     = (a == min_int) && (b == '1);  // most negative over -1
	if (!m_ext) begin
		if (funct3 == 3'b001) return a << amt;
		if (alt) return sa >>> amt;  // sign fill
		return a >> amt;
	end
	case (funct3)
		3'b000:  prod = a_zx * b_zx;  // low half is sign independent
		3'b001:  prod = a_sx * b_sx;
		3'b010:  prod = a_sx * b_zx;
		3'b011:  prod = a_zx * b_zx;
		3'b100: begin
			if (b_zero) return '1;
			if (ovf) return min_int;
			return sa / sb;  // truncates toward zero
		end
		3'b101: begin
			if (b_zero) return '1;
			return a / b;
		end
		3'b110: begin
			if (b_zero) return a;
			if (ovf) return '0;
			return sa % sb;  // sign of the dividend
		end
		default: begin
			if (b_zero) return a;
			return a % b;
		end
	endcase
	return (funct3 == 3'b000) ? prod[`MD_XLEN-1:0] : prod[2*`MD_XLEN-1:`MD_XLEN];
endfunction

`endif

/* bench/md_tb.sv */
/*
 * Testbench for md_top: directed corner cases, then seeded random operands.
 * Requests are strobed back to back whenever full is low.
 * Results are matched in issue order; the run stops at the first error.
 */
`include "md_params.svh"

module md_tb import md_pkg::*; ();
	localparam int XLEN        = `MD_XLEN;
	localparam int FULL_LIMIT  = 200;   // cycles full may stay high
	localparam int DRAIN_LIMIT = 2000;
	localparam int N_RANDOM    = 33;

	typedef struct packed {
		logic [2:0] funct3;
		logic       alt;
		logic       m_ext;
	} op_sel_t;

	typedef struct packed {
		op_sel_t         sel;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] want;
	} vec_t;

	localparam op_sel_t SEL_SLL    = '{3'b001, 1'b0, 1'b0};
	localparam op_sel_t SEL_SRL    = '{3'b101, 1'b0, 1'b0};
	localparam op_sel_t SEL_SRA    = '{3'b101, 1'b1, 1'b0};
	localparam op_sel_t SEL_MUL    = '{3'b000, 1'b0, 1'b1};
	localparam op_sel_t SEL_MULH   = '{3'b001, 1'b0, 1'b1};
	localparam op_sel_t SEL_MULHSU = '{3'b010, 1'b0, 1'b1};
	localparam op_sel_t SEL_MULHU  = '{3'b011, 1'b0, 1'b1};
	localparam op_sel_t SEL_DIV    = '{3'b100, 1'b0, 1'b1};
	localparam op_sel_t SEL_DIVU   = '{3'b101, 1'b0, 1'b1};
	localparam op_sel_t SEL_REM    = '{3'b110, 1'b0, 1'b1};
	localparam op_sel_t SEL_REMU   = '{3'b111, 1'b0, 1'b1};

	logic            clock;
	logic            reset;
	logic            req_valid;
	logic [2:0]      funct3;
	logic            alt;
	logic            m_ext;
	logic [XLEN-1:0] rs1;
	logic [XLEN-1:0] rs2;
	logic [4:0]      rd;
	logic            full;
	logic            res_valid;
	md_res_t         res;

	vec_t    vec_table [$];
	md_res_t score_q [$];  // expected results in issue order
	integer  seed;
	int      error_count;
	logic    seen_full;

	`include "md_tb_model.svh"

	md_top dut (
		.clock     (clock),
		.reset     (reset),
		.req_valid (req_valid),
		.funct3    (funct3),
		.alt       (alt),
		.m_ext     (m_ext),
		.rs1       (rs1),
		.rs2       (rs2),
		.rd        (rd),
		.full      (full),
		.res_valid (res_valid),
		.res       (res)
	);

	always #50 clock = ~clock;

	task automatic stop_failed();
		$display("Simulation FAILED");
		$fatal(1, "run stopped after the first error");
	endtask

	task automatic check_value(input string name, input logic [XLEN-1:0] actual,
		input logic [XLEN-1:0] expected);
		if (actual !== expected) begin
			error_count++;
			$display("[FAIL] t=%0t %s: expected 0x%08h, got 0x%08h",
				$time, name, expected, actual);
			stop_failed();
		end
	endtask

	task automatic add_vec(input op_sel_t sel, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b, input logic [XLEN-1:0] want);
		vec_table.push_back('{sel: sel, a: a, b: b, want: want});
	endtask

	task automatic wait_not_full();
		int cycles;
		cycles = 0;
		while (full) begin
			if (cycles == FULL_LIMIT) begin
				$display("timeout: full stayed high for %0d cycles", FULL_LIMIT);
				stop_failed();
			end
			@(negedge clock);
			cycles++;
		end
	endtask

	task automatic issue(input vec_t v, input logic [4:0] tag);
		wait_not_full();
		req_valid = 1'b1;
		funct3    = v.sel.funct3;
		alt       = v.sel.alt;
		m_ext     = v.sel.m_ext;
		rs1       = v.a;
		rs2       = v.b;
		rd        = tag;
		score_q.push_back('{data: v.want, rd: tag});
		@(negedge clock);
		req_valid = 1'b0;  // next issue may raise it again at once
	endtask

	task automatic wait_results();
		int cycles;
		cycles = 0;
		while (score_q.size() != 0) begin
			if (cycles == DRAIN_LIMIT) begin
				$display("timeout: %0d results still missing after %0d cycles",
					score_q.size(), DRAIN_LIMIT);
				stop_failed();
			end
			@(negedge clock);
			cycles++;
		end
	endtask

	// compare each result with the scoreboard head
	always @(negedge clock) begin
		md_res_t want;
		if (full) seen_full = 1'b1;
		if (!reset && res_valid) begin
			if (score_q.size() == 0) begin
				$display("result for rd %0d appeared with no request outstanding", res.rd);
				stop_failed();
			end else begin
				want = score_q.pop_front();
				check_value("res.rd", XLEN'(res.rd), XLEN'(want.rd));
				check_value("res.data", res.data, want.data);
			end
		end
	end

	initial begin
		op_sel_t         rand_ops [11];
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		clock       = 1'b0;
		reset       = 1'b1;
		req_valid   = 1'b0;
		funct3      = 3'b000;
		alt         = 1'b0;
		m_ext       = 1'b0;
		rs1         = '0;
		rs2         = '0;
		rd          = '0;
		seed        = 32'h05496d46;
		error_count = 0;
		seen_full   = 1'b0;

		add_vec(SEL_SLL, 32'h12345678, 32'h00000000, 32'h12345678);
		add_vec(SEL_SLL, 32'h00000001, 32'h0000001f, 32'h80000000);
		add_vec(SEL_SLL, 32'h00000003, 32'hffffffe1, 32'h00000006);  // only b[4:0]
		add_vec(SEL_SRL, 32'h87654321, 32'h00000000, 32'h87654321);
		add_vec(SEL_SRL, 32'h80000000, 32'h0000001f, 32'h00000001);
		add_vec(SEL_SRL, 32'hf0000000, 32'h00000001, 32'h78000000);
		add_vec(SEL_SRA, 32'h80000000, 32'h00000020, 32'h80000000);
		add_vec(SEL_SRA, 32'h80000000, 32'h0000001f, 32'hffffffff);
		add_vec(SEL_SRA, 32'hf0000000, 32'h00000001, 32'hf8000000);
		add_vec(SEL_SRA, 32'h7fffffff, 32'h00000024, 32'h07ffffff);
		add_vec(SEL_MUL, 32'h00000007, 32'hfffffffd, 32'hffffffeb);
		add_vec(SEL_MULH, 32'h00000007, 32'hfffffffd, 32'hffffffff);
		add_vec(SEL_MULHU, 32'hffffffff, 32'hffffffff, 32'hfffffffe);
		add_vec(SEL_MULHSU, 32'hffffffff, 32'hffffffff, 32'hffffffff);
		add_vec(SEL_MULH, 32'h80000000, 32'h80000000, 32'h40000000);
		add_vec(SEL_MUL, 32'h00000000, 32'h12345678, 32'h00000000);
		add_vec(SEL_DIV, 32'hfffffff9, 32'h00000002, 32'hfffffffd);
		add_vec(SEL_REM, 32'hfffffff9, 32'h00000002, 32'hffffffff);
		add_vec(SEL_DIV, 32'h00000007, 32'hfffffffe, 32'hfffffffd);
		add_vec(SEL_REM, 32'h00000007, 32'hfffffffe, 32'h00000001);
		add_vec(SEL_DIVU, 32'hfffffff9, 32'h00000002, 32'h7ffffffc);
		add_vec(SEL_REMU, 32'hfffffff9, 32'h00000002, 32'h00000001);
		add_vec(SEL_DIV, 32'h00000064, 32'h00000000, 32'hffffffff);  // divide by zero
		add_vec(SEL_DIVU, 32'h00000064, 32'h00000000, 32'hffffffff);
		add_vec(SEL_REM, 32'hffffff9c, 32'h00000000, 32'hffffff9c);
		add_vec(SEL_REMU, 32'h00000064, 32'h00000000, 32'h00000064);
		add_vec(SEL_DIV, 32'h80000000, 32'hffffffff, 32'h80000000);  // signed overflow
		add_vec(SEL_REM, 32'h80000000, 32'hffffffff, 32'h00000000);

		rand_ops = '{SEL_SLL, SEL_SRL, SEL_SRA, SEL_MUL, SEL_MULH, SEL_MULHSU,
			SEL_MULHU, SEL_DIV, SEL_DIVU, SEL_REM, SEL_REMU};
		for (int i = 0; i < N_RANDOM; i++) begin
			a = $random(seed);
			b = $random(seed);
			add_vec(rand_ops[i % 11], a, b, model_result(rand_ops[i % 11].funct3,
				rand_ops[i % 11].alt, rand_ops[i % 11].m_ext, a, b));
		end

		repeat (5) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		check_value("full", XLEN'(full), '0);
		check_value("res_valid", XLEN'(res_valid), '0);

		// ALU add is not decoded here and must give no result
		req_valid = 1'b1;
		rd        = 5'd31;
		@(negedge clock);
		req_valid = 1'b0;
		repeat (10) @(negedge clock);

		for (int i = 0; i < vec_table.size(); i++) begin
			issue(vec_table[i], 5'(i));  // rd doubles as the tag
		end
		wait_results();
		check_value("full seen in burst", XLEN'(seen_full), XLEN'(1));

		if (error_count == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			stop_failed();
		end
	end

endmodule

/* hdl/md_top.sv */
/*
 * Multiply/divide/shift block: decoder, request FIFO and iterative unit.
 * Callers must not strobe req_valid while full is high.
 * Results have no back-pressure and must be taken on res_valid.
 */
`include "md_params.svh"

module md_top import md_pkg::*; (
	input  logic                clock,
	input  logic                reset,
	input  logic                req_valid,
	input  logic [2:0]          funct3,
	input  logic                alt,    // funct7[5]
	input  logic                m_ext,  // funct7[0]
	input  logic [`MD_XLEN-1:0] rs1,
	input  logic [`MD_XLEN-1:0] rs2,
	input  logic [4:0]          rd,
	output logic                full,
	output logic                res_valid,
	output md_res_t             res
);
	logic    push;
	md_req_t dec_req;
	md_req_t head_req;
	logic    not_empty;
	logic    pop;

	md_decode u_decode (
		.clock     (clock),
		.reset     (reset),
		.req_valid (req_valid),
		.funct3    (funct3),
		.alt       (alt),
		.m_ext     (m_ext),
		.rs1       (rs1),
		.rs2       (rs2),
		.rd        (rd),
		.full      (full),
		.push      (push),
		.req       (dec_req)
	);

	md_req_fifo u_fifo (
		.clock     (clock),
		.reset     (reset),
		.push      (push),
		.req_in    (dec_req),
		.pop       (pop),
		.req_out   (head_req),
		.not_empty (not_empty),
		.full      (full)
	);

	md_iter_unit u_unit (
		.clock     (clock),
		.reset     (reset),
		.req       (head_req),
		.not_empty (not_empty),
		.pop       (pop),
		.res_valid (res_valid),
		.res       (res)
	);

endmodule

/* hdl/md_iter_unit.sv */
/*
 * One-bit-per-cycle execution of shifts, multiplies and divides.
 * Shifts take (b[4:0] + 1) cycles from pop to result, the others XLEN + 1.
 * Only one operation is in flight, so results leave in pop order.
 */
`include "md_params.svh"

module md_iter_unit import md_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  md_req_t req,
	input  logic    not_empty,
	output logic    pop,
	output logic    res_valid,
	output md_res_t res
);
	localparam int XLEN  = `MD_XLEN;
	localparam int CNT_W = $clog2(XLEN) + 1;

	typedef enum logic [2:0] {
		IDLE,
		SHIFT,
		MUL,
		DIV,
		DONE
	} state_e;

	state_e            state;
	logic [CNT_W-1:0]  cnt;        // steps left
	logic              last;
	md_op_e            op_q;
	logic              neg_q;      // product or quotient sign
	logic              rem_neg_q;  // remainder takes the dividend's sign
	logic              b_zero_q;
	md_res_t           res_q;

	logic [XLEN-1:0]   sh_data;
	logic [XLEN-1:0]   sh_next;

	logic [2*XLEN-1:0] prod;
	logic [2*XLEN-1:0] mcand;
	logic [XLEN-1:0]   mplier;
	logic [2*XLEN-1:0] prod_next;
	logic [2*XLEN-1:0] prod_fin;

	logic [2*XLEN-2:0] divisor;    // aligned under the dividend msb
	logic [XLEN-1:0]   rem;
	logic [XLEN-1:0]   quo;
	logic [XLEN-1:0]   mask;       // quotient bit of this step
	logic              div_fit;
	logic [XLEN-1:0]   rem_next;
	logic [XLEN-1:0]   quo_next;
	logic [XLEN-1:0]   rem_fin;
	logic [XLEN-1:0]   quo_fin;

	logic              a_sgn;
	logic              b_sgn;
	logic              a_neg;
	logic              b_neg;
	logic [XLEN-1:0]   a_mag;
	logic [XLEN-1:0]   b_mag;

	// signedness of the head entry's operands
	always_comb begin
		a_sgn = 1'b0;
		b_sgn = 1'b0;
		case (req.op)
			OP_MULH, OP_DIV, OP_REM: begin
				a_sgn = 1'b1;
				b_sgn = 1'b1;
			end
			OP_MULHSU: a_sgn = 1'b1;
			default:   a_sgn = 1'b0;  // MUL low half is sign independent
		endcase
	end

	assign a_neg = a_sgn & req.a[XLEN-1];
	assign b_neg = b_sgn & req.b[XLEN-1];
	assign a_mag = a_neg ? -req.a : req.a;
	assign b_mag = b_neg ? -req.b : req.b;

	always_comb begin
		case (op_q)
			OP_SLL:  sh_next = sh_data << 1;
			OP_SRL:  sh_next = sh_data >> 1;
			default: sh_next = $signed(sh_data) >>> 1;
		endcase
	end

	assign prod_next = mplier[0] ? prod + mcand : prod;
	assign prod_fin  = neg_q ? -prod_next : prod_next;

	assign div_fit  = (divisor <= {{(XLEN-1){1'b0}}, rem});
	assign rem_next = div_fit ? rem - divisor[XLEN-1:0] : rem;  // upper bits zero on fit
	assign quo_next = div_fit ? (quo | mask) : quo;
	assign rem_fin  = rem_neg_q ? -rem_next : rem_next;  // x/0 leaves rem = a
	assign quo_fin  = b_zero_q ? '1 : (neg_q ? -quo_next : quo_next);

	assign last = (cnt == CNT_W'(1));

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				IDLE: if (not_empty) begin
					case (req.op)
						OP_SLL, OP_SRL, OP_SRA: begin
							cnt   <= CNT_W'(req.b[4:0]);
							state <= (req.b[4:0] == 5'd0) ? DONE : SHIFT;
						end
						OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: begin
							cnt   <= CNT_W'(XLEN);
							state <= MUL;
						end
						default: begin
							cnt   <= CNT_W'(XLEN);
							state <= DIV;
						end
					endcase
				end
				SHIFT, MUL, DIV: begin
					cnt <= cnt - 1'b1;
					if (last) begin
						state <= DONE;
					end
				end
				default: state <= IDLE;  // DONE lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clock) begin
		case (state)
			IDLE: begin
				op_q       <= req.op;
				neg_q      <= a_neg ^ b_neg;
				rem_neg_q  <= a_neg;
				b_zero_q   <= (req.b == '0);
				res_q.rd   <= req.rd;
				res_q.data <= req.a;  // final value of a zero-amount shift
				sh_data    <= req.a;
				prod       <= '0;
				mcand      <= {{XLEN{1'b0}}, b_mag};
				mplier     <= a_mag;
				divisor    <= {b_mag, {(XLEN-1){1'b0}}};
				rem        <= a_mag;
				quo        <= '0;
				mask       <= {1'b1, {(XLEN-1){1'b0}}};
			end
			SHIFT: begin
				sh_data <= sh_next;
				if (last) begin
					res_q.data <= sh_next;
				end
			end
			MUL: begin
				prod   <= prod_next;
				mcand  <= mcand << 1;
				mplier <= mplier >> 1;
				if (last) begin
					res_q.data <= (op_q == OP_MUL) ? prod_fin[XLEN-1:0]
						: prod_fin[2*XLEN-1:XLEN];
				end
			end
			DIV: begin
				rem     <= rem_next;
				quo     <= quo_next;
				divisor <= divisor >> 1;
				mask    <= mask >> 1;
				if (last) begin
					res_q.data <= (op_q == OP_DIV || op_q == OP_DIVU) ? quo_fin : rem_fin;
				end
			end
			default: res_q <= res_q;  // hold while DONE
		endcase
	end

	assign pop       = (state == IDLE) & not_empty;
	assign res_valid = (state == DONE);
	assign res       = res_q;

endmodule

/* hdl/md_req_fifo.sv */
/*
 * Circular request queue of MD_FIFO_DEPTH entries.
 * A push while full or a pop while empty is ignored.
 * req_out shows the head entry whenever not_empty is high.
 */
`include "md_params.svh"

module md_req_fifo import md_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  logic    push,
	input  md_req_t req_in,
	input  logic    pop,
	output md_req_t req_out,
	output logic    not_empty,
	output logic    full
);
	localparam int DEPTH = `MD_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	md_req_t          mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;  // one bit wider to hold DEPTH
	logic             do_push;
	logic             do_pop;

	assign do_push = push & ~full;
	assign do_pop  = pop & not_empty;

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;  // wraps at power-of-two depth
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= req_in;
		end
	end

	assign req_out   = mem[rd_ptr];
	assign not_empty = (count != '0);
	assign full      = (count == (PTR_W + 1)'(DEPTH));

endmodule

/* hdl/md_decode.sv */
/*
 * Registers an OP-type instruction into a request, one cycle after req_valid.
 * A strobe while full is high, or an unsupported funct3/funct7 mix, is dropped.
 * If the FIFO fills between strobe and push, the request is held until it drains.
 */
`include "md_params.svh"

module md_decode import md_pkg::*; (
	input  logic                clock,
	input  logic                reset,
	input  logic                req_valid,
	input  logic [2:0]          funct3,
	input  logic                alt,
	input  logic                m_ext,
	input  logic [`MD_XLEN-1:0] rs1,
	input  logic [`MD_XLEN-1:0] rs2,
	input  logic [4:0]          rd,
	input  logic                full,
	output logic                push,
	output md_req_t             req
);
	md_op_e op_dec;
	logic   op_ok;
	logic   load;
	logic   pend;  // registered request not yet in the FIFO

	always_comb begin
		op_ok  = 1'b1;
		op_dec = OP_SLL;
		if (m_ext) begin
			case (funct3)
				3'b000:  op_dec = OP_MUL;
				3'b001:  op_dec = OP_MULH;
				3'b010:  op_dec = OP_MULHSU;
				3'b011:  op_dec = OP_MULHU;
				3'b100:  op_dec = OP_DIV;
				3'b101:  op_dec = OP_DIVU;
				3'b110:  op_dec = OP_REM;
				default: op_dec = OP_REMU;
			endcase
		end else if (funct3 == 3'b001 && !alt) begin
			op_dec = OP_SLL;
		end else if (funct3 == 3'b101) begin
			op_dec = alt ? OP_SRA : OP_SRL;  // funct7[5] picks arithmetic
		end else begin
			op_ok = 1'b0;  // add/sub/logic ops belong to the ALU
		end
	end

	assign load = req_valid & op_ok & ~full;

	always_ff @(posedge clock) begin
		if (reset) begin
			pend <= 1'b0;
		end else begin
			pend <= load | (pend & full);  // hold while the FIFO is full
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			req <= '{op: op_dec, a: rs1, b: rs2, rd: rd};
		end
	end

	assign push = pend & ~full;

endmodule

/* hdl/md_pkg.sv */
/*
 * Types shared by decoder, request FIFO and iterative unit.
 * Operation codes are internal to this block and do not follow the
 * RISC-V funct3 encoding.
 */
`include "md_params.svh"

package md_pkg;

	typedef enum logic [3:0] {
		OP_SLL    = 4'd0,
		OP_SRL    = 4'd1,
		OP_SRA    = 4'd2,
		OP_MUL    = 4'd3,
		OP_MULH   = 4'd4,
		OP_MULHSU = 4'd5,
		OP_MULHU  = 4'd6,
		OP_DIV    = 4'd7,
		OP_DIVU   = 4'd8,
		OP_REM    = 4'd9,
		OP_REMU   = 4'd10
	} md_op_e;

	// one queued operation
	typedef struct packed {
		md_op_e              op;
		logic [`MD_XLEN-1:0] a;  // rs1 value
		logic [`MD_XLEN-1:0] b;  // rs2 value
		logic [4:0]          rd;
	} md_req_t;

	// completed operation
	typedef struct packed {
		logic [`MD_XLEN-1:0] data;
		logic [4:0]          rd;
	} md_res_t;

endpackage

/* hdl/md_params.svh */
/*
 * Width and queue depth of the multiply/divide/shift block.
 * MD_FIFO_DEPTH must be a power of two from 2 to 16.
 * MD_XLEN other than 32 is untested with the decoder's 5-bit shift amount.
 */
`ifndef MD_PARAMS_SVH
`define MD_PARAMS_SVH

// operand and result width
`define MD_XLEN 32

// queued requests between decoder and unit
`define MD_FIFO_DEPTH 4

`endif
